//--- Bender.yml
package:
  name: rename_unit

sources:
  - files:
      - hw/arch_pkg.sv
      - hw/rename_pkg.sv
      - hw/map_tables.sv
      - hw/free_list.sv
      - hw/ready_list.sv
      - hw/rename_unit.sv
  - target: simulation
    files:
      - sim/rename_unit_asserts.sv
      - sim/rename_unit_tb.sv

//--- hw/arch_pkg.sv
// ======================================================================
// Architectural register count, register index type and the
// per-lane rename request struct
// ======================================================================

package arch_pkg;

    localparam int ARCH_REGS = 32;                  // Integer register file size

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // One lane of the rename group from the decoder
    typedef struct packed {
        logic      valid;                           // Lane carries an instruction
        arch_reg_t dest;                            // Register to be renamed
        arch_reg_t src_a;                           // First operand
        arch_reg_t src_b;                           // Second operand
    } rename_req_t;

endpackage

//--- hw/free_list.sv
// ======================================================================
// Speculative and committed free bitmaps, ordered allocation by
// priority search, release on commit and registered credit count
// ======================================================================

module free_list #(
    parameter int WAYS = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   except,
    input  logic                    [WAYS-1:0]     req_valid,
    input  rename_pkg::commit_t     [WAYS-1:0]     commit,
    input  rename_pkg::phys_reg_t   [WAYS-1:0]     freed_phys,
    output rename_pkg::phys_reg_t   [WAYS-1:0]     alloc_phys,
    output rename_pkg::credit_t                    free_credits
);

    localparam int FREE_AT_RESET = rename_pkg::PRF_COUNT - arch_pkg::ARCH_REGS;

    // Registers above the architectural range start out free
    localparam logic [rename_pkg::PRF_COUNT-1:0] RESET_FREE =
        {{FREE_AT_RESET{1'b1}}, {arch_pkg::ARCH_REGS{1'b0}}};

    logic [rename_pkg::PRF_COUNT-1:0] spec_free;
    logic [rename_pkg::PRF_COUNT-1:0] comm_free;
    logic [rename_pkg::PRF_COUNT-1:0] spec_next;
    logic [rename_pkg::PRF_COUNT-1:0] comm_next;
    logic [rename_pkg::PRF_COUNT-1:0] taken;        // Claimed by earlier lanes
    logic [rename_pkg::PRF_COUNT-1:0] avail;
    logic                             found;

    // Each lane takes the lowest index not yet claimed. Only valid
    // lanes claim, so the n-th valid lane gets the n-th free register.
    always_comb begin
        taken = '0;
        avail = '0;
        found = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            avail         = spec_free & ~taken;
            alloc_phys[i] = '0;
            found         = 1'b0;
            for (int p = 0; p < rename_pkg::PRF_COUNT; p++) begin
                if (avail[p] && !found) begin
                    alloc_phys[i] = rename_pkg::phys_reg_t'(p);
                    found         = 1'b1;
                end
            end
            if (req_valid[i] && found) begin
                taken[alloc_phys[i]] = 1'b1;
            end
        end
    end

    // Committed view: new mapping becomes owned, displaced one returns
    always_comb begin
        comm_next = comm_free;
        for (int i = 0; i < WAYS; i++) begin
            if (commit[i].valid) begin
                comm_next[commit[i].phys] = 1'b0;
                comm_next[freed_phys[i]]  = 1'b1;
            end
        end
    end

    always_comb begin
        spec_next = spec_free & ~taken;
        for (int i = 0; i < WAYS; i++) begin
            if (commit[i].valid) begin
                spec_next[freed_phys[i]] = 1'b1;    // Never allocated this cycle
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_free    <= RESET_FREE;
            comm_free    <= RESET_FREE;
            free_credits <= rename_pkg::credit_t'(FREE_AT_RESET);
        end else begin
            comm_free <= comm_next;
            if (except) begin
                spec_free    <= comm_next;          // In-flight allocations return
                free_credits <= rename_pkg::credit_t'($countones(comm_next));
            end else begin
                spec_free    <= spec_next;
                free_credits <= rename_pkg::credit_t'($countones(spec_next));
            end
        end
    end

endmodule

//--- hw/map_tables.sv
// ======================================================================
// Speculative (RAT) and committed (RRAT) alias tables, source
// lookups, displaced mapping with in-group forwarding, rollback
// ======================================================================

module map_tables #(
    parameter int WAYS = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   except,
    input  arch_pkg::rename_req_t   [WAYS-1:0]     req,
    input  rename_pkg::phys_reg_t   [WAYS-1:0]     alloc_phys,
    input  rename_pkg::commit_t     [WAYS-1:0]     commit,
    output rename_pkg::phys_reg_t   [WAYS-1:0]     src_a_phys,
    output rename_pkg::phys_reg_t   [WAYS-1:0]     src_b_phys,
    output rename_pkg::phys_reg_t   [WAYS-1:0]     freed_phys
);

    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] rat;       // Speculative map
    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] rrat;      // Committed map
    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] rat_next;
    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] rrat_next;

    // Source lookups see the table before this cycle's writes
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            src_a_phys[i] = rat[req[i].src_a];
            src_b_phys[i] = rat[req[i].src_b];
        end
    end

    // Mapping displaced by each commit lane. An earlier lane of the
    // same group retiring the same register has already replaced the
    // RRAT entry, so its register is the one that leaves the map.
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            freed_phys[i] = rrat[commit[i].arch];
            for (int j = 0; j < i; j++) begin
                if (commit[j].valid && commit[j].arch == commit[i].arch) begin
                    freed_phys[i] = commit[j].phys;     // Latest earlier lane wins
                end
            end
        end
    end

    // Renames in lane order, so the youngest lane owns the entry
    always_comb begin
        rat_next = rat;
        for (int i = 0; i < WAYS; i++) begin
            if (req[i].valid) begin
                rat_next[req[i].dest] = alloc_phys[i];
            end
        end
    end

    // Commits in lane order
    always_comb begin
        rrat_next = rrat;
        for (int i = 0; i < WAYS; i++) begin
            if (commit[i].valid) begin
                rrat_next[commit[i].arch] = commit[i].phys;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < arch_pkg::ARCH_REGS; a++) begin
                rat[a]  <= rename_pkg::phys_reg_t'(a);  // Identity mapping
                rrat[a] <= rename_pkg::phys_reg_t'(a);
            end
        end else begin
            rrat <= rrat_next;
            if (except) begin
                rat <= rrat_next;                       // Drop all speculative renames
            end else begin
                rat <= rat_next;
            end
        end
    end

endmodule

//--- hw/ready_list.sv
// ======================================================================
// Ready bit per physical register and source readiness lookup
// ======================================================================

module ready_list #(
    parameter int WAYS = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   except,
    input  arch_pkg::rename_req_t   [WAYS-1:0]     req,
    input  rename_pkg::phys_reg_t   [WAYS-1:0]     alloc_phys,
    input  rename_pkg::phys_reg_t   [WAYS-1:0]     src_a_phys,
    input  rename_pkg::phys_reg_t   [WAYS-1:0]     src_b_phys,
    input  rename_pkg::cdb_t        [WAYS-1:0]     cdb,
    output logic                    [WAYS-1:0]     src_a_ready,
    output logic                    [WAYS-1:0]     src_b_ready
);

    logic [rename_pkg::PRF_COUNT-1:0] ready;
    logic [rename_pkg::PRF_COUNT-1:0] ready_next;

    // Lookups use the registered bits only
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            src_a_ready[i] = ready[src_a_phys[i]];
            src_b_ready[i] = ready[src_b_phys[i]];
        end
    end

    always_comb begin
        ready_next = ready;
        for (int i = 0; i < WAYS; i++) begin
            if (req[i].valid) begin
                ready_next[alloc_phys[i]] = 1'b0;   // Value pending
            end
        end
        for (int i = 0; i < WAYS; i++) begin
            if (cdb[i].valid) begin
                ready_next[cdb[i].phys] = 1'b1;
            end
        end
    end

    // After a rollback only committed mappings are reachable, and
    // every one of them holds a written value
    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= '1;
        end else if (except) begin
            ready <= '1;
        end else begin
            ready <= ready_next;
        end
    end

endmodule

//--- hw/rename_pkg.sv
// ======================================================================
// Physical register types, credit count, rename response, commit
// and result bus lane structs
// ======================================================================

package rename_pkg;

    localparam int PRF_COUNT = 64;                  // Physical register file size

    typedef logic [$clog2(PRF_COUNT)-1:0]   phys_reg_t;
    typedef logic [$clog2(PRF_COUNT+1)-1:0] credit_t;   // Holds 0 to PRF_COUNT

    // One lane of rename results toward dispatch
    typedef struct packed {
        logic      valid;                           // Mirrors the request valid
        phys_reg_t dest_phys;                       // Newly allocated register
        phys_reg_t src_a_phys;
        logic      src_a_ready;                     // Value already written
        phys_reg_t src_b_phys;
        logic      src_b_ready;
    } rename_rsp_t;

    // One retiring instruction from the ROB, in program order by lane
    typedef struct packed {
        logic              valid;
        arch_pkg::arch_reg_t arch;                  // Destination being retired
        phys_reg_t         phys;                    // Its physical register
    } commit_t;

    // One result broadcast
    typedef struct packed {
        logic      valid;
        phys_reg_t phys;                            // Register now holding its value
    } cdb_t;

endpackage

//--- hw/rename_unit.sv
// ======================================================================
// Rename stage top level with map tables, free list and ready list
// ======================================================================

module rename_unit #(
    parameter int WAYS = 4
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   except,
    input  arch_pkg::rename_req_t   [WAYS-1:0]     req,
    input  rename_pkg::commit_t     [WAYS-1:0]     commit,
    input  rename_pkg::cdb_t        [WAYS-1:0]     cdb,
    output rename_pkg::rename_rsp_t [WAYS-1:0]     rsp,
    output rename_pkg::credit_t                    free_credits
);

    rename_pkg::phys_reg_t [WAYS-1:0] alloc_phys;
    rename_pkg::phys_reg_t [WAYS-1:0] freed_phys;
    rename_pkg::phys_reg_t [WAYS-1:0] src_a_phys;
    rename_pkg::phys_reg_t [WAYS-1:0] src_b_phys;
    logic                  [WAYS-1:0] src_a_ready;
    logic                  [WAYS-1:0] src_b_ready;
    logic                  [WAYS-1:0] req_valid;

    map_tables #(.WAYS(WAYS)) u_map_tables (
        .clock      (clock),
        .reset      (reset),
        .except     (except),
        .req        (req),
        .alloc_phys (alloc_phys),
        .commit     (commit),
        .src_a_phys (src_a_phys),
        .src_b_phys (src_b_phys),
        .freed_phys (freed_phys)
    );

    free_list #(.WAYS(WAYS)) u_free_list (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .req_valid    (req_valid),
        .commit       (commit),
        .freed_phys   (freed_phys),
        .alloc_phys   (alloc_phys),
        .free_credits (free_credits)
    );

    ready_list #(.WAYS(WAYS)) u_ready_list (
        .clock       (clock),
        .reset       (reset),
        .except      (except),
        .req         (req),
        .alloc_phys  (alloc_phys),
        .src_a_phys  (src_a_phys),
        .src_b_phys  (src_b_phys),
        .cdb         (cdb),
        .src_a_ready (src_a_ready),
        .src_b_ready (src_b_ready)
    );

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            req_valid[i]          = req[i].valid;
            rsp[i].valid          = req[i].valid;   // Same cycle as the request
            rsp[i].dest_phys      = alloc_phys[i];
            rsp[i].src_a_phys     = src_a_phys[i];
            rsp[i].src_a_ready    = src_a_ready[i];
            rsp[i].src_b_phys     = src_b_phys[i];
            rsp[i].src_b_ready    = src_b_ready[i];
        end
    end

endmodule

//--- sim/rename_unit_asserts.sv
// ======================================================================
// Concurrent assertions on reset state, unique allocation, credit
// limit and rollback, bound into the rename unit
// ======================================================================

module rename_unit_asserts #(
    parameter int WAYS = 4
) (
    input logic                                   clock,
    input logic                                   reset,
    input logic                                   except,
    input arch_pkg::rename_req_t   [WAYS-1:0]     req,
    input rename_pkg::rename_rsp_t [WAYS-1:0]     rsp,
    input rename_pkg::credit_t                    free_credits
);

    localparam int FREE_AT_RESET = rename_pkg::PRF_COUNT - arch_pkg::ARCH_REGS;

    int   fail_count = 0;                           // Failed assertion tally
    int   valid_count;
    logic dup_dest;                                 // Two valid lanes share a register
    logic all_ready;
    logic identity_map;                             // Lookup of r returns r

    always_comb begin
        valid_count  = 0;
        dup_dest     = 1'b0;
        all_ready    = 1'b1;
        identity_map = 1'b1;
        for (int i = 0; i < WAYS; i++) begin
            if (req[i].valid) valid_count++;
            all_ready = all_ready & rsp[i].src_a_ready & rsp[i].src_b_ready;
            if (rsp[i].src_a_phys != rename_pkg::phys_reg_t'(req[i].src_a) ||
                rsp[i].src_b_phys != rename_pkg::phys_reg_t'(req[i].src_b)) begin
                identity_map = 1'b0;
            end
            for (int j = 0; j < i; j++) begin
                if (req[i].valid && req[j].valid && rsp[i].dest_phys == rsp[j].dest_phys) begin
                    dup_dest = 1'b1;
                end
            end
        end
    end

    reset_state: assert property (@(posedge clock)
        $fell(reset) |-> (free_credits == FREE_AT_RESET && identity_map && all_ready))
        else begin
            $error("State after reset is not the identity map with full credits");
            fail_count++;
        end

    unique_dest: assert property (@(posedge clock) disable iff (reset) !dup_dest)
        else begin
            $error("Two valid lanes received the same physical register");
            fail_count++;
        end

    credit_limit: assert property (@(posedge clock) disable iff (reset)
        valid_count <= free_credits)
        else begin
            $error("More rename requests than free credits");
            fail_count++;
        end

    rollback_ready: assert property (@(posedge clock) disable iff (reset)
        except |=> all_ready)
        else begin
            $error("Source lookup not ready after exception rollback");
            fail_count++;
        end

    rollback_credits: assert property (@(posedge clock) disable iff (reset)
        except |=> free_credits == FREE_AT_RESET)
        else begin
            $error("Credits did not return to the committed free count after rollback");
            fail_count++;
        end

endmodule

//--- sim/rename_unit_tb.sv
// ======================================================================
// Rename stage testbench with random stimulus, reference model,
// value checks and closing report
// ======================================================================

module rename_unit_tb;

    localparam int WAYS        = 4;
    localparam int TEST_CYCLES = 500;
    localparam int MAX_CYCLES  = 600;               // Test length plus margin
    localparam int REG_SPAN    = 12;                // Narrow range so lanes collide

    typedef struct packed {
        arch_pkg::arch_reg_t   arch;
        rename_pkg::phys_reg_t phys;
        int                    stamp;               // Cycle of rename or broadcast
    } inflight_t;

    logic                               clock;
    logic                               reset;
    logic                               except;
    arch_pkg::rename_req_t   [WAYS-1:0] req;
    rename_pkg::commit_t     [WAYS-1:0] commit;
    rename_pkg::cdb_t        [WAYS-1:0] cdb;
    rename_pkg::rename_rsp_t [WAYS-1:0] rsp;
    rename_pkg::credit_t                free_credits;

    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] m_rat;     // Model speculative map
    rename_pkg::phys_reg_t [arch_pkg::ARCH_REGS-1:0] m_rrat;    // Model committed map
    logic [rename_pkg::PRF_COUNT-1:0] m_free;
    logic [rename_pkg::PRF_COUNT-1:0] m_cfree;
    logic [rename_pkg::PRF_COUNT-1:0] m_ready;

    inflight_t cdb_q[$];                            // Renamed, awaiting result
    inflight_t commit_q[$];                         // Result written, awaiting retire
    int        cycle_count;
    int        value_errors;
    int        assert_errors;
    int        seed;

    rename_unit #(.WAYS(WAYS)) UUT (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .req          (req),
        .commit       (commit),
        .cdb          (cdb),
        .rsp          (rsp),
        .free_credits (free_credits)
    );

    bind rename_unit rename_unit_asserts #(.WAYS(WAYS)) u_asserts (
        .clock        (clock),
        .reset        (reset),
        .except       (except),
        .req          (req),
        .rsp          (rsp),
        .free_credits (free_credits)
    );

    always #5 clock = ~clock;

    // Index of the n-th lowest set bit, counting from zero
    function automatic rename_pkg::phys_reg_t nth_free(
        input logic [rename_pkg::PRF_COUNT-1:0] pool,
        input int                               n
    );
        int seen;
        seen     = 0;
        nth_free = '0;
        for (int p = 0; p < rename_pkg::PRF_COUNT; p++) begin
            if (pool[p]) begin
                if (seen == n) nth_free = rename_pkg::phys_reg_t'(p);
                seen++;
            end
        end
    endfunction

    task automatic model_reset();
        for (int a = 0; a < arch_pkg::ARCH_REGS; a++) begin
            m_rat[a]  = rename_pkg::phys_reg_t'(a);
            m_rrat[a] = rename_pkg::phys_reg_t'(a);
        end
        for (int p = 0; p < rename_pkg::PRF_COUNT; p++) begin
            m_free[p] = (p >= arch_pkg::ARCH_REGS);
        end
        m_cfree = m_free;
        m_ready = '1;
        cdb_q.delete();
        commit_q.delete();
    endtask

    // Apply the inputs of the cycle that just ended
    task automatic model_step();
        logic [rename_pkg::PRF_COUNT-1:0] start_free;
        rename_pkg::phys_reg_t            displaced;
        inflight_t                        entry;
        int                               n;
        start_free = m_free;
        n          = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (commit[i].valid) begin
                displaced               = m_rrat[commit[i].arch];   // Sees earlier lanes
                m_rrat[commit[i].arch]  = commit[i].phys;
                m_cfree[commit[i].phys] = 1'b0;
                m_cfree[displaced]      = 1'b1;
                m_free[displaced]       = 1'b1;
            end
        end
        for (int i = 0; i < WAYS; i++) begin
            if (req[i].valid) begin
                entry.arch  = req[i].dest;
                entry.phys  = nth_free(start_free, n);
                entry.stamp = cycle_count;
                n++;
                m_free[entry.phys]  = 1'b0;
                m_ready[entry.phys] = 1'b0;
                m_rat[req[i].dest]  = entry.phys;
                if (!except) cdb_q.push_back(entry);
            end
        end
        for (int i = 0; i < WAYS; i++) begin
            if (cdb[i].valid) m_ready[cdb[i].phys] = 1'b1;
        end
        if (except) begin
            m_rat   = m_rrat;
            m_free  = m_cfree;
            m_ready = '1;
            cdb_q.delete();
            commit_q.delete();
        end
    endtask

    task automatic drive_idle();
        arch_pkg::rename_req_t [WAYS-1:0] next_req;
        next_req = '0;
        for (int i = 0; i < WAYS; i++) begin
            next_req[i].src_a = arch_pkg::arch_reg_t'($urandom_range(0, 31));
            next_req[i].src_b = arch_pkg::arch_reg_t'($urandom_range(0, 31));
        end
        req    <= next_req;
        commit <= '0;
        cdb    <= '0;
        except <= 1'b0;
    endtask

    task automatic drive_next();
        arch_pkg::rename_req_t [WAYS-1:0] next_req;
        rename_pkg::commit_t   [WAYS-1:0] next_commit;
        rename_pkg::cdb_t      [WAYS-1:0] next_cdb;
        inflight_t                        entry;
        int                               want;
        int                               budget;
        next_req    = '0;
        next_commit = '0;
        next_cdb    = '0;
        want        = $urandom_range(0, WAYS);
        for (int i = 0; i < want; i++) begin
            if (commit_q.size() > 0 && commit_q[0].stamp <= cycle_count - 3) begin
                entry                = commit_q.pop_front();
                next_commit[i].valid = 1'b1;
                next_commit[i].arch  = entry.arch;
                next_commit[i].phys  = entry.phys;
            end
        end
        want = $urandom_range(0, WAYS);
        for (int i = 0; i < want; i++) begin
            if (cdb_q.size() > 0 && cdb_q[0].stamp <= cycle_count - 2) begin
                entry             = cdb_q.pop_front();
                next_cdb[i].valid = 1'b1;
                next_cdb[i].phys  = entry.phys;
                entry.stamp       = cycle_count;
                commit_q.push_back(entry);      // Retire only after the result
            end
        end
        budget = $countones(m_free);            // Credits seen next cycle
        for (int i = 0; i < WAYS; i++) begin
            next_req[i].valid = ($urandom_range(0, 3) != 0) && (budget > 0);
            next_req[i].dest  = arch_pkg::arch_reg_t'($urandom_range(0, REG_SPAN - 1));
            next_req[i].src_a = arch_pkg::arch_reg_t'($urandom_range(0, REG_SPAN - 1));
            next_req[i].src_b = arch_pkg::arch_reg_t'($urandom_range(0, REG_SPAN - 1));
            if (next_req[i].valid) budget--;
        end
        req    <= next_req;
        commit <= next_commit;
        cdb    <= next_cdb;
        except <= ($urandom_range(0, 39) == 0);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %0h expected %0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_outputs();
        rename_pkg::phys_reg_t exp_a;
        rename_pkg::phys_reg_t exp_b;
        int                    n;
        n = 0;
        compare("free_credits", free_credits, $countones(m_free));
        for (int i = 0; i < WAYS; i++) begin
            compare($sformatf("rsp[%0d].valid", i), rsp[i].valid, req[i].valid);
            if (req[i].valid) begin
                exp_a = m_rat[req[i].src_a];
                exp_b = m_rat[req[i].src_b];
                compare($sformatf("rsp[%0d].dest_phys", i), rsp[i].dest_phys,
                        nth_free(m_free, n));
                compare($sformatf("rsp[%0d].src_a_phys", i), rsp[i].src_a_phys, exp_a);
                compare($sformatf("rsp[%0d].src_a_ready", i), rsp[i].src_a_ready,
                        m_ready[exp_a]);
                compare($sformatf("rsp[%0d].src_b_phys", i), rsp[i].src_b_phys, exp_b);
                compare($sformatf("rsp[%0d].src_b_ready", i), rsp[i].src_b_ready,
                        m_ready[exp_b]);
                n++;
            end
        end
    endtask

    always @(posedge clock) begin
        if (cycle_count == 0) begin
            seed = $urandom(81);                    // Stimulus runs in this process
        end
        if (reset) begin
            model_reset();
            drive_idle();
        end else begin
            model_step();
            drive_next();
        end
    end

    always @(negedge clock) begin
        if (!reset) check_outputs();                // Outputs settled mid-cycle
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        except        = 1'b0;
        req           = '0;
        commit        = '0;
        cdb           = '0;
        cycle_count   = 0;
        value_errors  = 0;
        assert_errors = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        wait (cycle_count >= TEST_CYCLES);
        @(posedge clock);                           // After the last mid-cycle check
        assert_errors = UUT.u_asserts.fail_count;
        $display("Errors: %0d value, %0d assertion", value_errors, assert_errors);
        if (value_errors == 0 && assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- src.f
hw/arch_pkg.sv
hw/rename_pkg.sv
hw/map_tables.sv
hw/free_list.sv
hw/ready_list.sv
hw/rename_unit.sv
sim/rename_unit_asserts.sv
sim/rename_unit_tb.sv
